//--- sim.f
+incdir+design
design/mrr_pkg.sv
design/chip_integrator.sv
design/pn_correlator.sv
design/tx_modulator.sv
design/loopback_ctrl.sv
design/mrr_loopback.sv
bench/tb_mrr_loopback.sv

//--- Makefile
TOP             ?= tb_mrr_loopback
FILELIST        ?= sim.f
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing --assert
BUILD_DIR       ?= obj_dir
PASS_MSG        := ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the Verilator build directory"
	@echo "variables: TOP FILELIST VERILATOR VERILATOR_FLAGS BUILD_DIR"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- bench/tb_mrr_loopback.sv
`include "mrr_params.svh"

module tb_mrr_loopback;

    import mrr_pkg::*;

    localparam int NUM_TESTS = 4;
    localparam int SAMPS_PER_BIT = 2 * `SAMPLES_PER_HALF;
    localparam int TX_SEND_SLOTS = `TX_BITS * `TX_SLOTS_PER_BIT;

    // half-bit energy bounds from the sample levels the frame generator uses
    localparam int HALF_HIGH_MIN = `SAMPLES_PER_HALF * 1000;
    localparam int HALF_HIGH_MAX = `SAMPLES_PER_HALF * 1063;
    localparam int HALF_LOW_MAX  = `SAMPLES_PER_HALF * 63;

    // junk bits, payload bits, turnaround slots and transmit disable per test
    int test_k [NUM_TESTS]    = '{0, 3, 1, 2};
    int test_n [NUM_TESTS]    = '{16, 20, 16, 17};
    int test_turn [NUM_TESTS] = '{2, 3, 1, 0};
    int test_dis [NUM_TESTS]  = '{0, 0, 1, 0};

    logic               clk = 1'b0;
    logic               rst;
    logic               i_trigger;
    lb_cfg_t            i_cfg;
    logic [`SAMP_W-1:0] i_samp;
    logic               i_samp_valid;
    logic               o_bit_valid;
    bit_rec_t           o_bit;
    logic               o_busy;
    logic               o_tx_en;
    logic               o_tx_keep;
    logic               o_detector_reset;
    logic               o_report_valid;
    report_t            o_report;

    integer       seed;
    int           errors;
    int           failed_tests;
    int           cycles;
    int           cycle_limit;
    logic         triggered;
    logic [255:0] frame_bits;
    logic [7:0]   exp_total;
    logic [1:0]   exp_k;
    logic [7:0]   rec_count;
    logic         tx_run;
    int           tx_cyc;
    int           tx_pos;
    int           tx_window;
    logic         tx_on;

    mrr_loopback dut0 (
        .clk              (clk),
        .rst              (rst),
        .i_trigger        (i_trigger),
        .i_cfg            (i_cfg),
        .i_samp           (i_samp),
        .i_samp_valid     (i_samp_valid),
        .o_bit_valid      (o_bit_valid),
        .o_bit            (o_bit),
        .o_busy           (o_busy),
        .o_tx_en          (o_tx_en),
        .o_tx_keep        (o_tx_keep),
        .o_detector_reset (o_detector_reset),
        .o_report_valid   (o_report_valid),
        .o_report         (o_report)
    );

    always #50 clk = ~clk;

    // keyed slot pattern of the reply word, lsb first, ones keyed early
    function automatic logic expected_keep(input int pos, input lb_cfg_t cfg);
        int slot;
        int bit_no;
        int sub;
        slot   = pos / `TX_SLOT_CYCLES - int'(cfg.turnaround_slots);
        bit_no = slot / `TX_SLOTS_PER_BIT;
        sub    = slot % `TX_SLOTS_PER_BIT;
        return cfg.tx_word[bit_no] ? (sub < 2) : (sub >= 2);
    endfunction

    task automatic record_failure(input string msg);
        errors = errors + 1;
        $display("CHECK FAILED at time %0t: %s", $time, msg);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    // k junk bits, the PN code msb first, then the payload
    task automatic build_frame(input int k, input int n);
        int i;
        logic [`PN_LEN-1:0] pn;
        pn = `PN_SEQ;
        frame_bits = '0;
        for (i = 0; i < k + `PN_LEN + n; i++) begin
            if (i >= k && i < k + `PN_LEN)
                frame_bits[i] = pn[`PN_LEN - 1 - (i - k)];
            else
                frame_bits[i] = $random(seed) & 1;
        end
    endtask

    task automatic send_frame(input int total);
        int b;
        int s;
        logic early;
        for (b = 0; b < total; b++) begin
            for (s = 0; s < SAMPS_PER_BIT; s++) begin
                // occasional gap in the sample stream
                if (($random(seed) & 3) == 0) begin
                    i_samp_valid = 1'b0;
                    next_cycle();
                end
                early = s < `SAMPLES_PER_HALF;
                if (early == frame_bits[b])
                    i_samp = 16'(1000 + ($random(seed) & 63));
                else
                    i_samp = 16'($random(seed) & 63);
                i_samp_valid = 1'b1;
                next_cycle();
            end
        end
        i_samp_valid = 1'b0;
    endtask

    task automatic run_test(input int test_no);
        int errors_before;
        int total;
        errors_before = errors;
        total = test_k[test_no] + `PN_LEN + test_n[test_no];
        build_frame(test_k[test_no], test_n[test_no]);
        i_cfg.payload_bits     = 8'(test_n[test_no]);
        i_cfg.turnaround_slots = 8'(test_turn[test_no]);
        i_cfg.tx_word          = $random(seed);
        i_cfg.tx_disable       = test_dis[test_no] != 0;
        exp_k     = 2'(test_k[test_no]);
        exp_total = 8'(total);
        i_trigger = 1'b1;
        triggered = 1'b1;
        next_cycle();
        i_trigger = 1'b0;
        send_frame(total);
        while (!o_report_valid)
            next_cycle();
        // let the report checks sample before the next frame is set up
        repeat (3) next_cycle();
        if (errors != errors_before)
            failed_tests = failed_tests + 1;
        $display("test %0d k=%0d payload=%0d turnaround=%0d tx_disable=%0d records=%0d: %s",
                 test_no, test_k[test_no], test_n[test_no], test_turn[test_no],
                 test_dis[test_no], rec_count, (errors == errors_before) ? "ok" : "failed");
    endtask

    // reference counters for record index and transmit slot position
    assign tx_on     = tx_run | o_tx_en;
    assign tx_pos    = tx_run ? tx_cyc : 0;
    assign tx_window = (int'(i_cfg.turnaround_slots) + TX_SEND_SLOTS) * `TX_SLOT_CYCLES;

    always @(posedge clk) begin
        if (rst || (i_trigger && !o_busy)) begin
            rec_count <= '0;
            tx_run    <= 1'b0;
            tx_cyc    <= 0;
        end else begin
            if (o_bit_valid)
                rec_count <= rec_count + 8'd1;
            if (tx_on) begin
                if (tx_pos == tx_window - 1) begin
                    tx_run <= 1'b0;
                    tx_cyc <= 0;
                end else begin
                    tx_run <= 1'b1;
                    tx_cyc <= tx_pos + 1;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("run timed out after %0d cycles without finishing the tests", cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    a_idle_outputs : assert property (@(posedge clk) disable iff (rst)
        !triggered |-> !(o_busy || o_bit_valid || o_tx_en || o_tx_keep ||
                         o_detector_reset || o_report_valid))
        else record_failure("control output high before the first trigger");

    a_bit_index : assert property (@(posedge clk) disable iff (rst)
        o_bit_valid |-> o_bit.idx == rec_count)
        else record_failure("bit record index out of sequence");

    a_bit_value : assert property (@(posedge clk) disable iff (rst)
        o_bit_valid |-> o_bit.value == frame_bits[o_bit.idx])
        else record_failure("decoded bit differs from the sent bit");

    a_bit_rule : assert property (@(posedge clk) disable iff (rst)
        o_bit_valid |-> o_bit.value == (o_bit.early > o_bit.late))
        else record_failure("bit value disagrees with its half-bit energies");

    // the keyed half holds four high samples and the other half four low ones
    a_bit_energy : assert property (@(posedge clk) disable iff (rst)
        o_bit_valid |-> (frame_bits[o_bit.idx] ?
            (o_bit.early >= HALF_HIGH_MIN && o_bit.early <= HALF_HIGH_MAX &&
             o_bit.late <= HALF_LOW_MAX) :
            (o_bit.late >= HALF_HIGH_MIN && o_bit.late <= HALF_HIGH_MAX &&
             o_bit.early <= HALF_LOW_MAX)))
        else record_failure("half-bit energy outside the range of the sent samples");

    a_bit_extra : assert property (@(posedge clk) disable iff (rst)
        o_bit_valid |-> rec_count < exp_total)
        else record_failure("more bit records than the frame holds");

    a_report_offset : assert property (@(posedge clk) disable iff (rst)
        o_report_valid |-> o_report.pn_offset == exp_k)
        else record_failure("reported PN offset wrong");

    a_report_count : assert property (@(posedge clk) disable iff (rst)
        o_report_valid |-> o_report.bit_count == exp_total && rec_count == exp_total)
        else record_failure("received bit count wrong");

    a_holdoff_first : assert property (@(posedge clk) disable iff (rst)
        o_report_valid |-> $past(o_detector_reset))
        else record_failure("report without detector holdoff before it");

    a_idle_after : assert property (@(posedge clk) disable iff (rst)
        o_report_valid |=> !o_busy)
        else record_failure("busy still high after the report");

    a_tx_window : assert property (@(posedge clk) disable iff (rst)
        tx_on && tx_pos < tx_window |-> o_tx_en)
        else record_failure("transmit enable dropped inside the reply window");

    a_tx_slot : assert property (@(posedge clk) disable iff (rst)
        tx_on && tx_pos % `TX_SLOT_CYCLES == `TX_SLOT_CYCLES / 2 &&
        tx_pos >= int'(i_cfg.turnaround_slots) * `TX_SLOT_CYCLES &&
        tx_pos < tx_window |-> o_tx_keep == expected_keep(tx_pos, i_cfg))
        else record_failure("keyed slot differs from the reply word");

    a_tx_disabled : assert property (@(posedge clk) disable iff (rst)
        i_cfg.tx_disable |-> !o_tx_en && !o_tx_keep)
        else record_failure("transmit active while disabled");

    initial begin
        int t;
        int budget;
        seed         = 65;
        errors       = 0;
        failed_tests = 0;
        cycles       = 0;
        cycle_limit  = 0;
        triggered    = 1'b0;
        exp_total    = '0;
        exp_k        = '0;
        frame_bits   = '0;
        rst          = 1'b1;
        i_trigger    = 1'b0;
        i_cfg        = '0;
        i_samp       = '0;
        i_samp_valid = 1'b0;
        // a sample takes at most two cycles with its gap
        budget = 0;
        for (t = 0; t < NUM_TESTS; t++) begin
            budget = budget + (test_k[t] + `PN_LEN + test_n[t]) * SAMPS_PER_BIT * 2;
            budget = budget + (test_turn[t] + TX_SEND_SLOTS) * `TX_SLOT_CYCLES;
            budget = budget + `HOLDOFF_CYCLES + 16;
        end
        cycle_limit = 4 * budget;
        repeat (4) @(posedge clk);
        #10;
        rst = 1'b0;
        repeat (5) next_cycle();
        for (t = 0; t < NUM_TESTS; t++)
            run_test(t);
        $display("tests run %0d, failing tests %0d, check failures %0d",
                 NUM_TESTS, failed_tests, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- design/mrr_loopback.sv
`include "mrr_params.svh"

module mrr_loopback (
    input  logic               clk,
    input  logic               rst,
    input  logic               i_trigger,
    input  mrr_pkg::lb_cfg_t   i_cfg,
    input  logic [`SAMP_W-1:0] i_samp,
    input  logic               i_samp_valid,
    output logic               o_bit_valid,
    output mrr_pkg::bit_rec_t  o_bit,
    output logic               o_busy,
    output logic               o_tx_en,
    output logic               o_tx_keep,
    output logic               o_detector_reset,
    output logic               o_report_valid,
    output mrr_pkg::report_t   o_report
);

    logic       rx_active;
    logic       search_done;
    logic [1:0] pn_offset;
    logic       tx_start;
    logic       tx_done;

    chip_integrator u_integrator (
        .clk          (clk),
        .rst          (rst),
        .i_samp       (i_samp),
        .i_samp_valid (i_samp_valid),
        .i_rx_active  (rx_active),
        .o_bit_valid  (o_bit_valid),
        .o_bit        (o_bit)
    );

    // decoded records feed both the correlator and the sequencer
    pn_correlator u_correlator (
        .clk           (clk),
        .rst           (rst),
        .i_rx_active   (rx_active),
        .i_bit_valid   (o_bit_valid),
        .i_bit         (o_bit),
        .o_search_done (search_done),
        .o_pn_offset   (pn_offset)
    );

    loopback_ctrl u_ctrl (
        .clk              (clk),
        .rst              (rst),
        .i_trigger        (i_trigger),
        .i_cfg            (i_cfg),
        .i_bit_valid      (o_bit_valid),
        .i_bit            (o_bit),
        .i_search_done    (search_done),
        .i_pn_offset      (pn_offset),
        .i_tx_done        (tx_done),
        .o_rx_active      (rx_active),
        .o_tx_start       (tx_start),
        .o_busy           (o_busy),
        .o_detector_reset (o_detector_reset),
        .o_report_valid   (o_report_valid),
        .o_report         (o_report)
    );

    tx_modulator u_modulator (
        .clk       (clk),
        .rst       (rst),
        .i_start   (tx_start),
        .i_cfg     (i_cfg),
        .o_tx_en   (o_tx_en),
        .o_tx_keep (o_tx_keep),
        .o_done    (tx_done)
    );

endmodule

//--- design/loopback_ctrl.sv
`include "mrr_params.svh"

module loopback_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_trigger,
    input  mrr_pkg::lb_cfg_t  i_cfg,
    input  logic              i_bit_valid,
    input  mrr_pkg::bit_rec_t i_bit,
    input  logic              i_search_done,
    input  logic [1:0]        i_pn_offset,
    input  logic              i_tx_done,
    output logic              o_rx_active,
    output logic              o_tx_start,
    output logic              o_busy,
    output logic              o_detector_reset,
    output logic              o_report_valid,
    output mrr_pkg::report_t  o_report
);

    import mrr_pkg::*;

    localparam int HOLD_W = $clog2(`HOLDOFF_CYCLES);

    lb_state_e         state;
    logic [7:0]        payload_bits;
    logic [7:0]        rx_count;
    logic [1:0]        pn_offset_q;
    logic [HOLD_W-1:0] hold_cnt;
    logic [8:0]        rx_total;
    logic [8:0]        frame_len;
    logic              rx_last;

    // frame ends after the offset junk bits, the PN code and the payload
    assign rx_total  = {1'b0, i_bit.idx} + 9'd1;
    assign frame_len = 9'(i_pn_offset) + 9'(`PN_LEN) + 9'(payload_bits);
    assign rx_last   = i_bit_valid && i_search_done && rx_total == frame_len;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= LB_IDLE;
            rx_count <= '0;
            hold_cnt <= '0;
        end else begin
            case (state)
                LB_IDLE: begin
                    if (i_trigger) begin
                        payload_bits <= i_cfg.payload_bits;
                        rx_count     <= '0;
                        state        <= LB_RECEIVE;
                    end
                end
                LB_RECEIVE: begin
                    if (i_bit_valid)
                        rx_count <= rx_count + 8'd1;
                    if (rx_last) begin
                        pn_offset_q <= i_pn_offset;
                        state       <= LB_TURNAROUND;
                    end
                end
                // single cycle that kicks off the modulator
                LB_TURNAROUND: state <= LB_TRANSMIT;
                LB_TRANSMIT: begin
                    if (i_tx_done) begin
                        hold_cnt <= '0;
                        state    <= LB_HOLDOFF;
                    end
                end
                LB_HOLDOFF: begin
                    hold_cnt <= hold_cnt + 1'b1;
                    if (hold_cnt == HOLD_W'(`HOLDOFF_CYCLES - 1))
                        state <= LB_REPORT;
                end
                LB_REPORT: state <= LB_IDLE;
                default: state <= LB_IDLE;
            endcase
        end
    end

    assign o_rx_active        = state == LB_RECEIVE;
    assign o_tx_start         = state == LB_TURNAROUND;
    assign o_busy             = state != LB_IDLE;
    assign o_detector_reset   = state == LB_HOLDOFF;
    assign o_report_valid     = state == LB_REPORT;
    assign o_report.pn_offset = pn_offset_q;
    assign o_report.bit_count = rx_count;

    a_report_pulse : assert property (@(posedge clk) disable iff (rst)
        o_report_valid |=> !o_report_valid)
        else $error("report valid held longer than one cycle");

endmodule

//--- design/tx_modulator.sv
`include "mrr_params.svh"

module tx_modulator (
    input  logic             clk,
    input  logic             rst,
    input  logic             i_start,
    input  mrr_pkg::lb_cfg_t i_cfg,
    output logic             o_tx_en,
    output logic             o_tx_keep,
    output logic             o_done
);

    localparam int CYC_W = $clog2(`TX_SLOT_CYCLES);
    localparam int BIT_W = $clog2(`TX_BITS);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_WAIT,
        TX_SEND
    } tx_phase_e;

    tx_phase_e           phase;
    logic [CYC_W-1:0]    cyc_cnt;
    logic [7:0]          slot_cnt;
    logic [BIT_W-1:0]    bit_cnt;
    logic [7:0]          wait_slots;
    logic [`TX_BITS-1:0] word_q;
    logic                disable_q;
    logic                slot_end;
    logic                bit_end;
    logic                send_last;

    assign slot_end  = cyc_cnt == CYC_W'(`TX_SLOT_CYCLES - 1);
    assign bit_end   = slot_end && slot_cnt == 8'(`TX_SLOTS_PER_BIT - 1);
    assign send_last = phase == TX_SEND && bit_end && bit_cnt == BIT_W'(`TX_BITS - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            phase    <= TX_IDLE;
            cyc_cnt  <= '0;
            slot_cnt <= '0;
            bit_cnt  <= '0;
            o_done   <= 1'b0;
        end else begin
            o_done  <= send_last;
            cyc_cnt <= (phase == TX_IDLE || slot_end) ? '0 : cyc_cnt + 1'b1;
            case (phase)
                TX_IDLE: begin
                    if (i_start) begin
                        slot_cnt <= '0;
                        bit_cnt  <= '0;
                        phase    <= (i_cfg.turnaround_slots == 8'd0) ? TX_SEND : TX_WAIT;
                    end
                end
                TX_WAIT: begin
                    if (slot_end) begin
                        if (slot_cnt == wait_slots - 8'd1) begin
                            slot_cnt <= '0;
                            phase    <= TX_SEND;
                        end else begin
                            slot_cnt <= slot_cnt + 8'd1;
                        end
                    end
                end
                TX_SEND: begin
                    if (bit_end) begin
                        slot_cnt <= '0;
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (send_last)
                            phase <= TX_IDLE;
                    end else if (slot_end) begin
                        slot_cnt <= slot_cnt + 8'd1;
                    end
                end
                default: phase <= TX_IDLE;
            endcase
        end
    end

    // reply word goes out lsb first
    always_ff @(posedge clk) begin
        if (phase == TX_IDLE && i_start) begin
            word_q     <= i_cfg.tx_word;
            wait_slots <= i_cfg.turnaround_slots;
            disable_q  <= i_cfg.tx_disable;
        end else if (phase == TX_SEND && bit_end) begin
            word_q <= word_q >> 1;
        end
    end

    assign o_tx_en = phase != TX_IDLE && !disable_q;
    // slot_cnt[1] picks the second half of a four-slot bit, ones key the first half
    assign o_tx_keep = phase == TX_SEND && !disable_q && (word_q[0] ^ slot_cnt[1]);

    a_keep_en : assert property (@(posedge clk) disable iff (rst)
        o_tx_keep |-> o_tx_en)
        else $error("keyed slot without transmit enable");

endmodule

//--- design/pn_correlator.sv
`include "mrr_params.svh"

module pn_correlator (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_rx_active,
    input  logic              i_bit_valid,
    input  mrr_pkg::bit_rec_t i_bit,
    output logic              o_search_done,
    output logic [1:0]        o_pn_offset
);

    import mrr_pkg::*;

    localparam logic [`PN_LEN-1:0] PN_CHIPS = `PN_SEQ;
    localparam int CHIP_W = $clog2(`PN_LEN);
    localparam int PRE_W = $clog2(`PREAMBLE_BITS + 1);
    localparam logic signed [5:0] SCORE_MIN = -6'sd16;

    pn_state_e                 state;
    logic [`PREAMBLE_BITS-1:0] pre_bits;
    logic [PRE_W-1:0]          pre_cnt;
    logic                      pre_shift;
    logic [1:0]                offset;
    logic [CHIP_W-1:0]         chip;
    logic [CHIP_W-1:0]         pn_idx;
    logic [PRE_W-1:0]          rd_idx;
    logic                      chip_match;
    logic signed [5:0]         score;
    logic signed [5:0]         best_score;
    logic [1:0]                best_off;

    // counted locally so a mismatch with the record index shows up
    assign pre_shift  = i_rx_active & i_bit_valid & (pre_cnt < PRE_W'(`PREAMBLE_BITS));
    assign rd_idx     = PRE_W'(offset) + PRE_W'(chip);
    assign pn_idx     = CHIP_W'(`PN_LEN - 1) - chip;
    assign chip_match = pre_bits[rd_idx] == PN_CHIPS[pn_idx];

    // newest bit enters at the top, so bit n ends up at position n
    always_ff @(posedge clk) begin
        if (pre_shift)
            pre_bits <= {i_bit.value, pre_bits[`PREAMBLE_BITS-1:1]};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= PN_IDLE;
            pre_cnt    <= '0;
            offset     <= '0;
            chip       <= '0;
            score      <= '0;
            best_score <= SCORE_MIN;
            best_off   <= '0;
        end else if (!i_rx_active) begin
            state   <= PN_IDLE;
            pre_cnt <= '0;
        end else begin
            if (pre_shift)
                pre_cnt <= pre_cnt + 1'b1;
            case (state)
                PN_IDLE: begin
                    if (pre_shift && pre_cnt == PRE_W'(`PREAMBLE_BITS - 1)) begin
                        offset     <= '0;
                        chip       <= '0;
                        score      <= '0;
                        best_score <= SCORE_MIN;
                        best_off   <= '0;
                        state      <= PN_SCORING;
                    end
                end
                PN_SCORING: begin
                    score <= score + (chip_match ? 6'sd1 : -6'sd1);
                    chip  <= chip + 1'b1;
                    if (chip == CHIP_W'(`PN_LEN - 1))
                        state <= PN_COMPARE;
                end
                PN_COMPARE: begin
                    // strict compare keeps the earliest offset on a tie
                    if (score > best_score) begin
                        best_score <= score;
                        best_off   <= offset;
                    end
                    score <= '0;
                    chip  <= '0;
                    if (offset == 2'(`SEARCH_LEN - 1)) begin
                        state <= PN_DONE;
                    end else begin
                        offset <= offset + 2'd1;
                        state  <= PN_SCORING;
                    end
                end
                default: ;
            endcase
        end
    end

    assign o_search_done = state == PN_DONE;
    assign o_pn_offset   = best_off;

    a_pre_idx : assert property (@(posedge clk) disable iff (rst)
        pre_shift |-> i_bit.idx < 8'(`PREAMBLE_BITS))
        else $error("preamble capture out of step with bit index");

endmodule

//--- design/chip_integrator.sv
`include "mrr_params.svh"

module chip_integrator (
    input  logic               clk,
    input  logic               rst,
    input  logic [`SAMP_W-1:0] i_samp,
    input  logic               i_samp_valid,
    input  logic               i_rx_active,
    output logic               o_bit_valid,
    output mrr_pkg::bit_rec_t  o_bit
);

    localparam int SAMPS_PER_BIT = 2 * `SAMPLES_PER_HALF;
    localparam int CNT_W = $clog2(SAMPS_PER_BIT);

    logic [CNT_W-1:0]  samp_cnt;
    logic [`ACC_W-1:0] early_sum;
    logic [`ACC_W-1:0] late_sum;
    logic [7:0]        bit_idx;
    logic [`ACC_W-1:0] samp_ext;
    logic [`ACC_W-1:0] late_final;
    logic              take;
    logic              in_early;
    logic              last_samp;

    assign samp_ext   = {{(`ACC_W - `SAMP_W){1'b0}}, i_samp};
    assign take       = i_rx_active & i_samp_valid;
    assign in_early   = samp_cnt < CNT_W'(`SAMPLES_PER_HALF);
    assign last_samp  = samp_cnt == CNT_W'(SAMPS_PER_BIT - 1);
    // last sample of a bit always falls in the late half
    assign late_final = late_sum + samp_ext;

    // sample position and bit index, held clear outside a receive
    always_ff @(posedge clk) begin
        if (rst) begin
            samp_cnt    <= '0;
            bit_idx     <= '0;
            o_bit_valid <= 1'b0;
        end else begin
            o_bit_valid <= 1'b0;
            if (!i_rx_active) begin
                samp_cnt <= '0;
                bit_idx  <= '0;
            end else if (i_samp_valid) begin
                if (last_samp) begin
                    samp_cnt    <= '0;
                    bit_idx     <= bit_idx + 8'd1;
                    o_bit_valid <= 1'b1;
                end else begin
                    samp_cnt <= samp_cnt + 1'b1;
                end
            end
        end
    end

    // half-bit sums restart on the first sample of each half
    always_ff @(posedge clk) begin
        if (take) begin
            if (samp_cnt == '0)
                early_sum <= samp_ext;
            else if (in_early)
                early_sum <= early_sum + samp_ext;
            if (samp_cnt == CNT_W'(`SAMPLES_PER_HALF))
                late_sum <= samp_ext;
            else if (!in_early)
                late_sum <= late_sum + samp_ext;
        end
        if (take && last_samp) begin
            o_bit.idx   <= bit_idx;
            o_bit.early <= early_sum;
            o_bit.late  <= late_final;
            // energy in the early half means a one
            o_bit.value <= early_sum > late_final;
        end
    end

    a_bit_in_rx : assert property (@(posedge clk) disable iff (rst)
        $rose(o_bit_valid) |-> i_rx_active)
        else $error("bit record issued outside a receive");

endmodule

//--- design/mrr_pkg.sv
`include "mrr_params.svh"

package mrr_pkg;

    // one decoded bit with both half-bit energies
    typedef struct packed {
        logic [7:0]        idx;
        logic              value;
        logic [`ACC_W-1:0] early;
        logic [`ACC_W-1:0] late;
    } bit_rec_t;

    // end of run summary
    typedef struct packed {
        logic [1:0] pn_offset;
        logic [7:0] bit_count;
    } report_t;

    typedef struct packed {
        logic [7:0]          payload_bits;
        logic [7:0]          turnaround_slots;
        logic [`TX_BITS-1:0] tx_word;
        logic                tx_disable;
    } lb_cfg_t;

    typedef enum logic [2:0] {
        LB_IDLE,
        LB_RECEIVE,
        LB_TURNAROUND,
        LB_TRANSMIT,
        LB_HOLDOFF,
        LB_REPORT
    } lb_state_e;

    typedef enum logic [1:0] {
        PN_IDLE,
        PN_SCORING,
        PN_COMPARE,
        PN_DONE
    } pn_state_e;

endpackage

//--- design/mrr_params.svh
`ifndef MRR_PARAMS_SVH
`define MRR_PARAMS_SVH

// energy sample and half-bit accumulator widths
`define SAMP_W            16
`define SAMPLES_PER_HALF  4
`define ACC_W             (`SAMP_W + 3)

// preamble PN code, most significant chip is sent first
`define PN_LEN            15
`define PN_SEQ            15'b000100110101111
`define SEARCH_LEN        4
`define PREAMBLE_BITS     (`PN_LEN + `SEARCH_LEN)

// reply transmission
`define TX_BITS           32
`define TX_SLOTS_PER_BIT  4
`define TX_SLOT_CYCLES    8

// detector held in reset after the reply
`define HOLDOFF_CYCLES    64

`endif
